// ==== lvds_cfg_pkg.sv ====
/* word width and link constants of the sensor LVDS model
   imported by the RTL blocks and by the testbench */

package lvds_cfg_pkg;

	// --------------------------------------------------------------------------
	// serial word format
	// --------------------------------------------------------------------------

	// 10-bit mode of the sensor, one word per lane per load strobe
	localparam int DATA_WIDTH = 10;

	// bit slot counter inside one word
	localparam int WORD_CNT_W = $clog2(DATA_WIDTH);

	// payload of one lane, data or sync
	typedef logic [DATA_WIDTH-1:0] word_t;

	// --------------------------------------------------------------------------
	// link notes
	// --------------------------------------------------------------------------

	// words go out MSB first, one bit per clk
	// forwarded clock toggles every clk, so one period spans two bits
	// lanes are packed with lane 0 in the low bits of the parallel bus
	// no back-pressure, the link is free-running

endpackage

// ==== sensor_codes_pkg.sv ====
/* sync-lane code words and data-lane training word of the sensor interface
   used by the timing and pattern blocks and by the testbench */

package sensor_codes_pkg;

	// --------------------------------------------------------------------------
	// sync lane codes, 10-bit mode
	// --------------------------------------------------------------------------

	// first active slot of the first line
	localparam lvds_cfg_pkg::word_t CODE_FS = 10'h2AA;

	// first active slot of every other line
	localparam lvds_cfg_pkg::word_t CODE_LS = 10'h0AA;

	// last active slot of a line that is not the last
	localparam lvds_cfg_pkg::word_t CODE_LE = 10'h12A;

	// last active slot of the last line
	localparam lvds_cfg_pkg::word_t CODE_FE = 10'h32A;

	// remaining active slots
	localparam lvds_cfg_pkg::word_t CODE_IMG = 10'h035;

	// blank slots and idle link
	localparam lvds_cfg_pkg::word_t CODE_BLK = 10'h015;

	// --------------------------------------------------------------------------
	// data lane filler
	// --------------------------------------------------------------------------

	// receiver locks its word alignment on this one
	localparam lvds_cfg_pkg::word_t TRAINING = 10'h3A6;

endpackage

// ==== word_rate_gen.sv ====
/* word load strobe for the serializer, one clk pulse per DATA_WIDTH cycles
   the strobe also steps the timing and pattern blocks */

`timescale 1ns/100ps

module word_rate_gen (
	input  logic clk,
	input  logic i_rst,
	output logic o_word_load
);

	import lvds_cfg_pkg::*;

	// bit slot within the current word
	logic [WORD_CNT_W-1:0] bit_cnt;

	// modulo DATA_WIDTH, zero right after reset
	always_ff @(posedge clk) begin
		if (i_rst) begin
			bit_cnt <= '0;
		end else if (bit_cnt == WORD_CNT_W'(DATA_WIDTH - 1)) begin
			bit_cnt <= '0;
		end else begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// strobe on the last bit slot
	// so the load edge lines up with the end of the previous word
	assign o_word_load = (bit_cnt == WORD_CNT_W'(DATA_WIDTH - 1));

	// single-cycle strobe, never back to back
	a_strobe_single : assert property (
		@(posedge clk) disable iff (i_rst)
		o_word_load |=> !o_word_load
	);

endmodule

// ==== frame_timing.sv ====
/* frame position of the sensor link, one step per word load strobe
   gives the sync code and the active flag of the slot that loads next */

`timescale 1ns/100ps

module frame_timing #(
	parameter int LINE_WORDS        = 6,
	parameter int LINE_BLANK_WORDS  = 2,
	parameter int FRAME_LINES       = 3,
	parameter int FRAME_BLANK_LINES = 1
) (
	input  logic                clk,
	input  logic                i_rst,
	input  logic                i_word_load,
	input  logic                i_stream_en,
	output lvds_cfg_pkg::word_t o_ctrl_word,
	output logic                o_active,
	output logic                o_frame_start
);

	import lvds_cfg_pkg::*;
	import sensor_codes_pkg::*;

	// slots per line and lines per frame, blanking included
	localparam int SLOT_NUM = LINE_WORDS + LINE_BLANK_WORDS;
	localparam int LINE_NUM = FRAME_LINES + FRAME_BLANK_LINES;
	// one spare bit so every bound fits the counter
	localparam int SLOT_W = $clog2(SLOT_NUM + 1);
	localparam int LINE_W = $clog2(LINE_NUM + 1);

	logic              running;
	logic [SLOT_W-1:0] slot_cnt;
	logic [LINE_W-1:0] line_cnt;
	logic              last_slot;
	logic              last_line;

	assign last_slot = (slot_cnt == SLOT_W'(SLOT_NUM - 1));
	assign last_line = (line_cnt == LINE_W'(LINE_NUM - 1));

	// --------------------------------------------------------------------------
	// position counters
	// --------------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (i_rst) begin
			running  <= 1'b0;
			slot_cnt <= '0;
			line_cnt <= '0;
		end else if (i_word_load) begin
			if (!running) begin
				// idle, frame begins with the slot after this strobe
				running  <= i_stream_en;
				slot_cnt <= '0;
				line_cnt <= '0;
			end else if (last_slot) begin
				slot_cnt <= '0;
				if (last_line) begin
					// enable only sampled at frame boundary
					line_cnt <= '0;
					running  <= i_stream_en;
				end else begin
					line_cnt <= line_cnt + 1'b1;
				end
			end else begin
				slot_cnt <= slot_cnt + 1'b1;
			end
		end
	end

	// --------------------------------------------------------------------------
	// slot decode
	// --------------------------------------------------------------------------

	assign o_active = running && (slot_cnt < SLOT_W'(LINE_WORDS))
		&& (line_cnt < LINE_W'(FRAME_LINES));
	assign o_frame_start = running && (slot_cnt == '0) && (line_cnt == '0);

	always_comb begin
		o_ctrl_word = CODE_BLK;
		if (o_active) begin
			if (slot_cnt == '0) begin
				o_ctrl_word = (line_cnt == '0) ? CODE_FS : CODE_LS;
			end else if (slot_cnt == SLOT_W'(LINE_WORDS - 1)) begin
				o_ctrl_word = (line_cnt == LINE_W'(FRAME_LINES - 1)) ? CODE_FE : CODE_LE;
			end else begin
				o_ctrl_word = CODE_IMG;
			end
		end
	end

	// slot counter stays inside the line
	a_slot_range : assert property (
		@(posedge clk) disable iff (i_rst)
		slot_cnt < SLOT_W'(SLOT_NUM)
	);

endmodule

// ==== pixel_pattern_gen.sv ====
/* incrementing test pattern for the data lanes, lane 0 in the low bits
   blank and idle slots carry the training word */

`timescale 1ns/100ps

module pixel_pattern_gen #(
	parameter int CHANNEL_NUM = 4
) (
	input  logic                                            clk,
	input  logic                                            i_rst,
	input  logic                                            i_word_load,
	input  logic                                            i_active,
	input  logic                                            i_frame_start,
	output logic [CHANNEL_NUM*lvds_cfg_pkg::DATA_WIDTH-1:0] o_pix_data
);

	import lvds_cfg_pkg::*;
	import sensor_codes_pkg::*;

	// pixel number of lane 0 for the next active slot
	word_t base_cnt;
	// base actually used in this slot, zero on the first slot of a frame
	word_t base_now;

	assign base_now = i_frame_start ? '0 : base_cnt;

	// --------------------------------------------------------------------------
	// base counter
	// --------------------------------------------------------------------------

	// steps by one pixel per lane on every loaded active slot
	// wraps modulo 2^DATA_WIDTH
	always_ff @(posedge clk) begin
		if (i_rst) begin
			base_cnt <= '0;
		end else if (i_word_load && i_active) begin
			base_cnt <= base_now + word_t'(CHANNEL_NUM);
		end
	end

	// --------------------------------------------------------------------------
	// lane words
	// --------------------------------------------------------------------------

	genvar ch;
	generate
		for (ch = 0; ch < CHANNEL_NUM; ch = ch + 1) begin : g_lane
			// pixel c of the slot, or filler outside active video
			assign o_pix_data[DATA_WIDTH*ch +: DATA_WIDTH] =
				i_active ? word_t'(base_now + word_t'(ch)) : TRAINING;
		end
	endgenerate

endmodule

// ==== serializer_python.sv ====
/* sensor-style LVDS serializer, parallel load on the word strobe then MSB first
   data lanes, sync lane and forwarded clock as true/complement pairs */

`timescale 1ns/100ps

module serializer_python #(
	parameter int CHANNEL_NUM = 4
) (
	input  logic                                            clk,
	input  logic                                            i_rst,
	input  logic                                            i_clk_en,
	input  logic [CHANNEL_NUM*lvds_cfg_pkg::DATA_WIDTH-1:0] iv_pix_data,
	input  lvds_cfg_pkg::word_t                             iv_ctrl_data,
	output logic                                            o_clk_p,
	output logic                                            o_clk_n,
	output logic                                            o_ctrl_p,
	output logic                                            o_ctrl_n,
	output logic [CHANNEL_NUM-1:0]                          ov_data_p,
	output logic [CHANNEL_NUM-1:0]                          ov_data_n
);

	import lvds_cfg_pkg::*;

	word_t shift_data [CHANNEL_NUM];
	word_t shift_ctrl;
	logic  clk_ser;

	// --------------------------------------------------------------------------
	// data lanes
	// --------------------------------------------------------------------------

	genvar ch;
	generate
		for (ch = 0; ch < CHANNEL_NUM; ch = ch + 1) begin : g_lane
			// load on strobe, else rotate left so the next bit reaches the MSB
			always_ff @(posedge clk) begin
				if (i_rst) begin
					shift_data[ch] <= '0;
				end else if (i_clk_en) begin
					shift_data[ch] <= iv_pix_data[DATA_WIDTH*ch +: DATA_WIDTH];
				end else begin
					shift_data[ch] <= {shift_data[ch][DATA_WIDTH-2:0],
						shift_data[ch][DATA_WIDTH-1]};
				end
			end

			assign ov_data_p[ch] = shift_data[ch][DATA_WIDTH-1];
			assign ov_data_n[ch] = ~shift_data[ch][DATA_WIDTH-1];
		end
	endgenerate

	// --------------------------------------------------------------------------
	// sync lane
	// --------------------------------------------------------------------------

	// same shifting as a data lane
	always_ff @(posedge clk) begin
		if (i_rst) begin
			shift_ctrl <= '0;
		end else if (i_clk_en) begin
			shift_ctrl <= iv_ctrl_data;
		end else begin
			shift_ctrl <= {shift_ctrl[DATA_WIDTH-2:0], shift_ctrl[DATA_WIDTH-1]};
		end
	end

	assign o_ctrl_p = shift_ctrl[DATA_WIDTH-1];
	assign o_ctrl_n = ~shift_ctrl[DATA_WIDTH-1];

	// forwarded clock at half the bit rate and low after reset
	always_ff @(posedge clk) begin
		if (i_rst) begin
			clk_ser <= 1'b0;
		end else begin
			clk_ser <= ~clk_ser;
		end
	end

	assign o_clk_p = clk_ser;
	assign o_clk_n = ~clk_ser;

endmodule

// ==== python_lvds_tx.sv ====
/* top of the sensor LVDS output model, free-running link
   i_stream_en starts frames, lowering it ends streaming at a frame boundary */

`timescale 1ns/100ps

module python_lvds_tx #(
	parameter int CHANNEL_NUM       = 4,
	parameter int LINE_WORDS        = 6,
	parameter int LINE_BLANK_WORDS  = 2,
	parameter int FRAME_LINES       = 3,
	parameter int FRAME_BLANK_LINES = 1
) (
	input  logic                   clk,
	input  logic                   i_rst,
	input  logic                   i_stream_en,
	output logic                   o_clk_p,
	output logic                   o_clk_n,
	output logic                   o_ctrl_p,
	output logic                   o_ctrl_n,
	output logic [CHANNEL_NUM-1:0] ov_data_p,
	output logic [CHANNEL_NUM-1:0] ov_data_n
);

	import lvds_cfg_pkg::*;

	logic                              word_load;
	word_t                             ctrl_word;
	logic                              active;
	logic                              frame_start;
	logic [CHANNEL_NUM*DATA_WIDTH-1:0] pix_data;

	// word strobe
	word_rate_gen u_word_rate_gen (.clk, .i_rst, .o_word_load(word_load));

	// sync code and active flag per slot
	frame_timing #(
		.LINE_WORDS(LINE_WORDS), .LINE_BLANK_WORDS(LINE_BLANK_WORDS),
		.FRAME_LINES(FRAME_LINES), .FRAME_BLANK_LINES(FRAME_BLANK_LINES)
	) u_frame_timing (
		.clk, .i_rst, .i_word_load(word_load), .i_stream_en,
		.o_ctrl_word(ctrl_word), .o_active(active), .o_frame_start(frame_start)
	);

	// lane words
	pixel_pattern_gen #(.CHANNEL_NUM(CHANNEL_NUM)) u_pixel_pattern_gen (
		.clk, .i_rst, .i_word_load(word_load), .i_active(active),
		.i_frame_start(frame_start), .o_pix_data(pix_data)
	);

	// serial pairs
	serializer_python #(.CHANNEL_NUM(CHANNEL_NUM)) u_serializer_python (
		.clk, .i_rst, .i_clk_en(word_load), .iv_pix_data(pix_data), .iv_ctrl_data(ctrl_word),
		.o_clk_p, .o_clk_n, .o_ctrl_p, .o_ctrl_n, .ov_data_p, .ov_data_n
	);

endmodule

// ==== tb_python_lvds_tx.sv ====
/* testbench of the sensor LVDS output model, applies a stream enable table
   and checks the deserialized lanes against a frame reference model */

`timescale 1ns/100ps

module tb_python_lvds_tx;

	import lvds_cfg_pkg::*;
	import sensor_codes_pkg::*;

	localparam int CHANNEL_NUM       = 4;
	localparam int LINE_WORDS        = 6;
	localparam int LINE_BLANK_WORDS  = 2;
	localparam int FRAME_LINES       = 3;
	localparam int FRAME_BLANK_LINES = 1;
	localparam int SLOT_NUM    = LINE_WORDS + LINE_BLANK_WORDS;
	localparam int LINE_NUM    = FRAME_LINES + FRAME_BLANK_LINES;
	localparam int FRAME_SLOTS = SLOT_NUM * LINE_NUM;
	localparam int ROWS        = 7;
	localparam int HIST_LEN    = 1024;

	logic                   clk = 1'b0;
	logic                   i_rst;
	logic                   i_stream_en;
	logic                   o_clk_p, o_clk_n, o_ctrl_p, o_ctrl_n;
	logic [CHANNEL_NUM-1:0] ov_data_p, ov_data_n;

	// stimulus table with enable level and length in word slots
	logic  tbl_en [ROWS];
	int    tbl_slots [ROWS];
	// cycles since reset release
	int    cyc = 0;
	// enable level seen at each load strobe
	int    strobe_cnt = 0;
	logic  en_hist [HIST_LEN];
	int    tick = 0;
	int    timeout_limit;
	// deserialized words and reference model position
	word_t cap_ctrl;
	word_t cap_data [CHANNEL_NUM];
	int    word_cnt = 0;
	logic  m_running = 1'b0;
	int    m_slot = 0;
	int    m_line = 0;

	python_lvds_tx #(
		.CHANNEL_NUM(CHANNEL_NUM), .LINE_WORDS(LINE_WORDS),
		.LINE_BLANK_WORDS(LINE_BLANK_WORDS), .FRAME_LINES(FRAME_LINES),
		.FRAME_BLANK_LINES(FRAME_BLANK_LINES)
	) dut (
		.clk, .i_rst, .i_stream_en, .o_clk_p, .o_clk_n, .o_ctrl_p, .o_ctrl_n,
		.ov_data_p, .ov_data_n
	);

	always #10 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "simulation stopped at %0t", $time);
	endtask

	task automatic compare_word(input string name, input word_t exp, input word_t act);
		assert (act === exp) else
			fail_run($sformatf("MISMATCH t=%0t %s expected=%h actual=%h",
				$time, name, exp, act));
	endtask

	// sync code from the slot meanings of the frame structure
	function automatic word_t expected_ctrl();
		if (!m_running || m_slot >= LINE_WORDS || m_line >= FRAME_LINES) return CODE_BLK;
		if (m_slot == 0) return (m_line == 0) ? CODE_FS : CODE_LS;
		if (m_slot == LINE_WORDS - 1) return (m_line == FRAME_LINES - 1) ? CODE_FE : CODE_LE;
		return CODE_IMG;
	endfunction

	// pixel y*W*N + x*N + c in active slots and filler in the others
	function automatic word_t expected_lane(input int c);
		if (!m_running || m_slot >= LINE_WORDS || m_line >= FRAME_LINES) return TRAINING;
		return word_t'((m_line * LINE_WORDS * CHANNEL_NUM + m_slot * CHANNEL_NUM + c)
			% (1 << DATA_WIDTH));
	endfunction

	// step one slot and take the enable only while idle or after the last blank line
	task automatic advance_model(input logic en);
		if (!m_running) begin
			m_running = en;
		end else if (m_slot == SLOT_NUM - 1) begin
			m_slot = 0;
			if (m_line == LINE_NUM - 1) begin
				m_line    = 0;
				m_running = en;
			end else begin
				m_line = m_line + 1;
			end
		end else begin
			m_slot = m_slot + 1;
		end
	endtask

	task automatic check_slot();
		compare_word("o_ctrl_p word", expected_ctrl(), cap_ctrl);
		for (int c = 0; c < CHANNEL_NUM; c++) begin
			compare_word($sformatf("ov_data_p[%0d] word", c), expected_lane(c), cap_data[c]);
		end
		advance_model(en_hist[word_cnt % HIST_LEN]);
		word_cnt = word_cnt + 1;
	endtask

	// ------------------------------------------------------------------------
	// strobe tracking and timeout
	// ------------------------------------------------------------------------

	// first strobe DATA_WIDTH cycles after reset and every DATA_WIDTH after that
	always @(posedge clk) begin
		if (i_rst) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
			if (cyc >= DATA_WIDTH - 1 && (cyc - (DATA_WIDTH - 1)) % DATA_WIDTH == 0) begin
				en_hist[strobe_cnt % HIST_LEN] <= i_stream_en;
				strobe_cnt <= strobe_cnt + 1;
			end
		end
	end

	always @(posedge clk) begin
		tick <= tick + 1;
		if (tick >= timeout_limit) fail_run("timeout, the stimulus table did not complete");
	end

	// ------------------------------------------------------------------------
	// serial capture at the falling edge where the outputs are settled
	// ------------------------------------------------------------------------

	always @(negedge clk) begin
		int bit_idx;
		assert ((ov_data_n === ~ov_data_p) && (o_ctrl_n === ~o_ctrl_p) && (o_clk_n === ~o_clk_p))
			else fail_run($sformatf("MISMATCH t=%0t n outputs expected=%b_%b_%b actual=%b_%b_%b",
				$time, ~o_clk_p, ~o_ctrl_p, ~ov_data_p, o_clk_n, o_ctrl_n, ov_data_n));
		// forwarded clock starts low and toggles every clk
		assert (o_clk_p === cyc[0]) else
			fail_run($sformatf("MISMATCH t=%0t o_clk_p expected=%b actual=%b",
				$time, cyc[0], o_clk_p));
		if (cyc < DATA_WIDTH) begin
			// nothing loaded yet
			assert ((ov_data_p === '0) && (o_ctrl_p === 1'b0)) else
				fail_run($sformatf("MISMATCH t=%0t p outputs expected=0 actual=%b_%b",
					$time, o_ctrl_p, ov_data_p));
		end else begin
			bit_idx  = (cyc - DATA_WIDTH) % DATA_WIDTH;
			cap_ctrl = {cap_ctrl[DATA_WIDTH-2:0], o_ctrl_p};
			for (int c = 0; c < CHANNEL_NUM; c++) begin
				cap_data[c] = {cap_data[c][DATA_WIDTH-2:0], ov_data_p[c]};
			end
			// MSB first, so the LSB closes the word
			if (bit_idx == DATA_WIDTH - 1) check_slot();
		end
	end

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------

	initial begin
		int total_slots;
		i_rst       = 1'b1;
		i_stream_en = 1'b0;
		void'($urandom(32'h2293_d60d));
		// idle then two frames and part of a third, drop, random idle, re-enable and drain
		tbl_en[0]    = 1'b0;
		tbl_slots[0] = 5;
		tbl_en[1]    = 1'b1;
		tbl_slots[1] = 2 * FRAME_SLOTS;
		tbl_en[2]    = 1'b1;
		tbl_slots[2] = 12;
		tbl_en[3]    = 1'b0;
		tbl_slots[3] = FRAME_SLOTS + 8;
		tbl_en[4]    = 1'b0;
		tbl_slots[4] = 3 + int'($urandom % 6);
		tbl_en[5]    = 1'b1;
		tbl_slots[5] = FRAME_SLOTS + 8;
		tbl_en[6]    = 1'b0;
		tbl_slots[6] = FRAME_SLOTS + 8;
		total_slots = 0;
		for (int r = 0; r < ROWS; r++) total_slots = total_slots + tbl_slots[r];
		timeout_limit = total_slots * DATA_WIDTH + 100;

		repeat (3) @(posedge clk);
		#2 i_rst = 1'b0;
		for (int r = 0; r < ROWS; r++) begin
			i_stream_en = tbl_en[r];
			repeat (tbl_slots[r] * DATA_WIDTH) @(posedge clk);
			#2;
		end

		$display("No errors");
		$finish;
	end

endmodule

// ==== compile.f ====
lvds_cfg_pkg.sv
sensor_codes_pkg.sv
word_rate_gen.sv
frame_timing.sv
pixel_pattern_gen.sv
serializer_python.sv
python_lvds_tx.sv
tb_python_lvds_tx.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it, exit status gives the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert \
	--top-module tb_python_lvds_tx \
	-f compile.f \
	-o tb_python_lvds_tx_sim \
	&& ./obj_dir/tb_python_lvds_tx_sim \
	|| { echo "simulation failed"; exit 1; }
exit 0
